/* logic/snd_pkg.sv */
// Sound board package
// Widths, host address windows, voice register map and PCM gain table
`default_nettype none

package snd_pkg;

    // Bus widths
    localparam int HOST_AW = 16;        // Host address
    localparam int ROM_AW  = 19;        // Sample/program ROM address
    localparam int DW      = 8;         // Data byte
    localparam int SND_W   = 16;        // Mixed output

    // Host address windows
    localparam logic [HOST_AW-1:0] ROM_WIN_END = 16'hEFFF;  // ROM visible up to here
    localparam logic [HOST_AW-1:0] REG_BASE    = 16'hF000;  // Register page, 256 bytes

    // Voice register map, offsets in the low nibble
    localparam int REG_VOICE_BIT = 4;   // 0 voice 0, 1 voice 1

    localparam logic [3:0] REG_START0 = 4'd0;   // Start address, low byte
    localparam logic [3:0] REG_START1 = 4'd1;
    localparam logic [3:0] REG_START2 = 4'd2;   // Bits 18:16 only
    localparam logic [3:0] REG_END0   = 4'd3;   // End address, inclusive
    localparam logic [3:0] REG_END1   = 4'd4;
    localparam logic [3:0] REG_END2   = 4'd5;
    localparam logic [3:0] REG_CTRL   = 4'd6;   // Bit 0 key-on, bit 1 loop
    localparam logic [3:0] REG_STATUS = 4'd7;   // Read only, bit 0 playing

    localparam logic [DW-1:0] UNMAPPED_RD = 8'hFF;  // Open bus value

    // ROM requesters
    localparam int N_REQ    = 3;
    localparam int REQ_HOST = 0;        // Highest priority
    localparam int REQ_V0   = 1;
    localparam int REQ_V1   = 2;

    // Effect level gains in 4.4 fixed point, index is fxlevel
    localparam logic [3:0][DW-1:0] PCM_GAIN = {8'h14, 8'h08, 8'h04, 8'h02};

endpackage

`default_nettype wire

/* logic/snd_bus_if.sv */
// Voice register bus
// Host decoder drives address, data and strobes, the voice returns read data
`timescale 1ns/1ps
`default_nettype none

interface snd_bus_if import snd_pkg::*; ();

    logic [7:0]    addr;    // Offset in register page
    logic [DW-1:0] wdata;
    logic          wr;      // Single cycle write strobe
    logic          rd;      // Read strobe, only when voice selected
    logic [DW-1:0] rdata;   // Zero unless rd

    modport host (
        output addr,
        output wdata,
        output wr,
        output rd,
        input  rdata
    );

    modport voice (
        input  addr,
        input  wdata,
        input  wr,
        input  rd,
        output rdata
    );

endinterface

`default_nettype wire

/* logic/rom_req_if.sv */
// ROM request channel
// Requester holds cs and addr until ok, ok carries valid data for one cycle
`timescale 1ns/1ps
`default_nettype none

interface rom_req_if import snd_pkg::*; ();

    logic              cs;
    logic [ROM_AW-1:0] addr;
    logic              ok;      // One cycle, only to the granted requester
    logic [DW-1:0]     data;

    modport requester (
        output cs,
        output addr,
        input  ok,
        input  data
    );

    modport arbiter (
        input  cs,
        input  addr,
        output ok,
        output data
    );

endinterface

`default_nettype wire

/* logic/snd_host_decode.sv */
// Host address decoder
// Splits host space into ROM window, voice register page and open bus.
// ROM reads wait for ok, register and open bus reads answer next cycle.
`timescale 1ns/1ps
`default_nettype none

module snd_host_decode import snd_pkg::*; (
    input  wire                 clk,
    input  wire                 rst,

    input  wire [HOST_AW-1:0]   host_addr,
    input  wire [DW-1:0]        host_wdata,
    input  wire                 host_wr,
    input  wire                 host_rd,
    output logic [DW-1:0]       host_rdata,
    output logic                host_rvalid,

    snd_bus_if.host             v0_bus,
    snd_bus_if.host             v1_bus,
    rom_req_if.requester        rom
);

    logic               rom_win;    // 0000-EFFF
    logic               reg_cs;     // F000-F0FF
    logic               vsel;       // Voice select bit
    logic               rom_pend;   // ROM read in flight
    logic [HOST_AW-1:0] rom_addr_q;
    logic [DW-1:0]      reg_rdata;

    // Chip selects, anything else is open bus
    assign rom_win = host_addr <= ROM_WIN_END;
    assign reg_cs  = host_addr[HOST_AW-1:8] == REG_BASE[HOST_AW-1:8];
    assign vsel    = host_addr[REG_VOICE_BIT];

    // Register strobes go to one voice only
    assign v0_bus.addr  = host_addr[7:0];
    assign v0_bus.wdata = host_wdata;
    assign v0_bus.wr    = host_wr && reg_cs && !vsel;
    assign v0_bus.rd    = host_rd && reg_cs && !vsel;

    assign v1_bus.addr  = host_addr[7:0];
    assign v1_bus.wdata = host_wdata;
    assign v1_bus.wr    = host_wr && reg_cs && vsel;
    assign v1_bus.rd    = host_rd && reg_cs && vsel;

    assign reg_rdata = vsel ? v1_bus.rdata : v0_bus.rdata;

    // ROM window maps straight onto the low ROM addresses
    assign rom.cs   = rom_pend;
    assign rom.addr = {{(ROM_AW-HOST_AW){1'b0}}, rom_addr_q};

    always_ff @(posedge clk) begin
        if (rst) begin
            rom_pend    <= 1'b0;
            host_rvalid <= 1'b0;
        end else begin
            host_rvalid <= (host_rd && !rom_win) || rom.ok;  // One cycle pulse
            if (host_rd && rom_win)
                rom_pend <= 1'b1;
            else if (rom.ok)
                rom_pend <= 1'b0;   // cs drops the cycle after ok
        end
    end

    // Read data path
    always_ff @(posedge clk) begin
        if (host_rd && rom_win)
            rom_addr_q <= host_addr;    // Held until ok
        if (rom.ok)
            host_rdata <= rom.data;
        else if (host_rd && !rom_win)
            host_rdata <= reg_cs ? reg_rdata : UNMAPPED_RD;
    end

endmodule

`default_nettype wire

/* logic/pcm_voice.sv */
// PCM voice
// Start, end and control registers, one byte prefetch from ROM.
// Prefetched byte moves to the output on cen, then the next byte is requested.
`timescale 1ns/1ps
`default_nettype none

module pcm_voice import snd_pkg::*; (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 cen,        // Sample tick
    snd_bus_if.voice            regs,
    rom_req_if.requester        rom,
    output logic signed [DW-1:0] voice_out
);

    logic [ROM_AW-1:0] start_addr, end_addr, cur_addr;
    logic              keyon, loop;
    logic              playing;
    logic              fetching;    // cs held
    logic              restart;     // Key-on waiting for a free ROM channel
    logic              pf_valid, pf_last;
    logic [DW-1:0]     pf_data;
    logic              ending;      // End byte is on the output
    logic              ctrl_wr;

    assign ctrl_wr  = regs.wr && regs.addr[3:0] == REG_CTRL;
    assign rom.cs   = fetching;
    assign rom.addr = cur_addr;

    // Address registers
    always_ff @(posedge clk) begin
        if (regs.wr) begin
            case (regs.addr[3:0])
                REG_START0: start_addr[7:0]         <= regs.wdata;
                REG_START1: start_addr[15:8]        <= regs.wdata;
                REG_START2: start_addr[ROM_AW-1:16] <= regs.wdata[ROM_AW-17:0];
                REG_END0:   end_addr[7:0]           <= regs.wdata;
                REG_END1:   end_addr[15:8]          <= regs.wdata;
                REG_END2:   end_addr[ROM_AW-1:16]   <= regs.wdata[ROM_AW-17:0];
                default: ;
            endcase
        end
    end

    always_comb begin
        regs.rdata = '0;
        if (regs.rd) begin
            case (regs.addr[3:0])
                REG_START0: regs.rdata = start_addr[7:0];
                REG_START1: regs.rdata = start_addr[15:8];
                REG_START2: regs.rdata = {5'd0, start_addr[ROM_AW-1:16]};
                REG_END0:   regs.rdata = end_addr[7:0];
                REG_END1:   regs.rdata = end_addr[15:8];
                REG_END2:   regs.rdata = {5'd0, end_addr[ROM_AW-1:16]};
                REG_CTRL:   regs.rdata = {6'd0, loop, keyon};
                REG_STATUS: regs.rdata = {7'd0, playing};
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            {playing, fetching, restart, ending} <= 4'd0;
            {pf_valid, pf_last, keyon, loop}     <= 4'd0;
            voice_out <= '0;
        end else begin
            if (rom.ok)
                fetching <= 1'b0;
            // A restart discards whatever fetch was in flight
            if (restart && (!fetching || rom.ok)) begin
                restart  <= 1'b0;
                fetching <= 1'b1;
                cur_addr <= start_addr;
            end else if (rom.ok) begin
                pf_valid <= 1'b1;
                pf_data  <= rom.data;
                pf_last  <= cur_addr == end_addr;
                cur_addr <= (cur_addr == end_addr) ? start_addr : cur_addr + 1'b1;
            end
            if (cen && playing && !restart) begin
                if (ending) begin           // One-shot done
                    playing   <= 1'b0;
                    ending    <= 1'b0;
                    voice_out <= '0;
                end else if (pf_valid) begin    // Else old sample repeats
                    voice_out <= pf_data;
                    pf_valid  <= 1'b0;
                    if (pf_last && !loop)
                        ending <= 1'b1;
                    else
                        fetching <= 1'b1;   // Next byte, wraps in loop mode
                end
            end
            if (ctrl_wr) begin
                keyon <= regs.wdata[0];
                loop  <= regs.wdata[1];
                if (regs.wdata[0]) begin
                    playing  <= 1'b1;
                    restart  <= 1'b1;
                    pf_valid <= 1'b0;
                    ending   <= 1'b0;
                end else begin      // Key-off stops at once
                    playing   <= 1'b0;
                    restart   <= 1'b0;
                    voice_out <= '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/rom_arbiter.sv */
// ROM port arbiter
// Host has fixed priority, the two voices alternate.
// Grant is locked from the first cs until ok.
`timescale 1ns/1ps
`default_nettype none

module rom_arbiter import snd_pkg::*; (
    input  wire                 clk,
    input  wire                 rst,
    rom_req_if.arbiter          host_req,
    rom_req_if.arbiter          v0_req,
    rom_req_if.arbiter          v1_req,
    output logic [ROM_AW-1:0]   rom_addr,
    output logic                rom_cs,
    input  wire [DW-1:0]        rom_data,
    input  wire                 rom_ok
);

    logic [N_REQ-1:0] pick;     // Fresh choice when idle
    logic [N_REQ-1:0] gnt_q;    // Locked grant
    logic [N_REQ-1:0] gnt;
    logic             busy;
    logic             rr_v1;    // Voice 1 wins the next tie

    always_comb begin
        pick = '0;
        if (host_req.cs)
            pick[REQ_HOST] = 1'b1;
        else if (v0_req.cs && v1_req.cs)
            pick[rr_v1 ? REQ_V1 : REQ_V0] = 1'b1;
        else if (v0_req.cs)
            pick[REQ_V0] = 1'b1;
        else if (v1_req.cs)
            pick[REQ_V1] = 1'b1;
    end

    assign gnt    = busy ? gnt_q : pick;
    assign rom_cs = |gnt;

    always_comb begin
        rom_addr = '0;
        if (gnt[REQ_HOST])
            rom_addr = host_req.addr;
        else if (gnt[REQ_V0])
            rom_addr = v0_req.addr;
        else if (gnt[REQ_V1])
            rom_addr = v1_req.addr;
    end

    // ok and data back to the owner only
    assign host_req.ok   = rom_ok && gnt[REQ_HOST];
    assign v0_req.ok     = rom_ok && gnt[REQ_V0];
    assign v1_req.ok     = rom_ok && gnt[REQ_V1];
    assign host_req.data = gnt[REQ_HOST] ? rom_data : '0;
    assign v0_req.data   = gnt[REQ_V0]   ? rom_data : '0;
    assign v1_req.data   = gnt[REQ_V1]   ? rom_data : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            gnt_q <= '0;
            rr_v1 <= 1'b0;
        end else if (rom_ok) begin
            busy  <= 1'b0;
            gnt_q <= '0;
            if (gnt[REQ_V0])
                rr_v1 <= 1'b1;  // Other voice next time
            else if (gnt[REQ_V1])
                rr_v1 <= 1'b0;
        end else if (!busy && rom_cs) begin
            busy  <= 1'b1;
            gnt_q <= pick;
        end
    end

endmodule

`default_nettype wire

/* logic/snd_mixer.sv */
// PCM mixer
// 4.4 gain from the effect level table, two voices summed and saturated.
// Output and sample strobe come two cycles after cen.
`timescale 1ns/1ps
`default_nettype none

module snd_mixer import snd_pkg::*; (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     cen,
    input  wire                     enable_pcm,
    input  wire  [1:0]              fxlevel,
    input  wire  signed [DW-1:0]    voice0,
    input  wire  signed [DW-1:0]    voice1,
    output logic signed [SND_W-1:0] snd,
    output logic                    sample,
    output logic                    peak
);

    logic [DW-1:0]                 gain;
    logic signed [SND_W+DW:0]      p0, p1;    // 16 bit sample times 9 bit gain
    logic signed [SND_W+DW-4:0]    s0, s1;    // After the 4.4 shift
    logic signed [SND_W+DW-3:0]    sum;
    logic                          sat;
    logic                          cen_d;     // Voices valid here

    assign gain = enable_pcm ? PCM_GAIN[fxlevel] : '0;

    // Gain is unsigned, keep its top bit out of the sign
    assign p0 = $signed({voice0, 8'd0}) * $signed({1'b0, gain});
    assign p1 = $signed({voice1, 8'd0}) * $signed({1'b0, gain});
    assign s0 = p0[SND_W+DW:4];
    assign s1 = p1[SND_W+DW:4];
    assign sum = s0 + s1;

    // Overflow when the bits above the output sign disagree
    assign sat = !(&sum[SND_W+DW-3:SND_W-1] || ~|sum[SND_W+DW-3:SND_W-1]);

    always_ff @(posedge clk) begin
        if (rst) begin
            cen_d  <= 1'b0;
            sample <= 1'b0;
            peak   <= 1'b0;
            snd    <= '0;
        end else begin
            cen_d  <= cen;
            sample <= cen_d;
            peak   <= cen_d && sat;     // Pulses with sample
            if (cen_d) begin
                if (sat)
                    snd <= {sum[SND_W+DW-3], {(SND_W-1){~sum[SND_W+DW-3]}}};
                else
                    snd <= sum[SND_W-1:0];
            end
        end
    end

endmodule

`default_nettype wire

/* logic/snd_sys.sv */
// Sound board sample playback top
// Host decoder, two PCM voices, shared ROM arbiter and mixer
`timescale 1ns/1ps
`default_nettype none

module snd_sys import snd_pkg::*; (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     cen,        // Sample tick

    input  wire  [1:0]              fxlevel,
    input  wire                     enable_pcm,

    // Host bus
    input  wire  [HOST_AW-1:0]      host_addr,
    input  wire  [DW-1:0]           host_wdata,
    input  wire                     host_wr,
    input  wire                     host_rd,
    output logic [DW-1:0]           host_rdata,
    output logic                    host_rvalid,

    // Sample/program ROM
    output logic [ROM_AW-1:0]       rom_addr,
    output logic                    rom_cs,
    input  wire  [DW-1:0]           rom_data,
    input  wire                     rom_ok,

    output logic signed [SND_W-1:0] snd,
    output logic                    sample,
    output logic                    peak
);

    logic signed [DW-1:0] v0_out, v1_out;

    snd_bus_if v0_bus ();
    snd_bus_if v1_bus ();
    rom_req_if host_rom ();
    rom_req_if v0_rom ();
    rom_req_if v1_rom ();

    snd_host_decode u_decode (
        .clk         (clk),
        .rst         (rst),
        .host_addr   (host_addr),
        .host_wdata  (host_wdata),
        .host_wr     (host_wr),
        .host_rd     (host_rd),
        .host_rdata  (host_rdata),
        .host_rvalid (host_rvalid),
        .v0_bus      (v0_bus.host),
        .v1_bus      (v1_bus.host),
        .rom         (host_rom.requester)
    );

    pcm_voice u_voice0 (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .regs      (v0_bus.voice),
        .rom       (v0_rom.requester),
        .voice_out (v0_out)
    );

    pcm_voice u_voice1 (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .regs      (v1_bus.voice),
        .rom       (v1_rom.requester),
        .voice_out (v1_out)
    );

    rom_arbiter u_arb (
        .clk      (clk),
        .rst      (rst),
        .host_req (host_rom.arbiter),
        .v0_req   (v0_rom.arbiter),
        .v1_req   (v1_rom.arbiter),
        .rom_addr (rom_addr),
        .rom_cs   (rom_cs),
        .rom_data (rom_data),
        .rom_ok   (rom_ok)
    );

    snd_mixer u_mixer (
        .clk        (clk),
        .rst        (rst),
        .cen        (cen),
        .enable_pcm (enable_pcm),
        .fxlevel    (fxlevel),
        .voice0     (v0_out),
        .voice1     (v1_out),
        .snd        (snd),
        .sample     (sample),
        .peak       (peak)
    );

endmodule

`default_nettype wire

/* dv/snd_sys_asserts.sv */
// ROM arbiter checks
// Address hold and a single live grant on the shared ROM port
`timescale 1ns/1ps
`default_nettype none

module snd_sys_asserts import snd_pkg::*; (
    input wire              clk,
    input wire              rst,
    input wire              rom_cs,
    input wire              rom_ok,
    input wire [ROM_AW-1:0] rom_addr,
    input wire [N_REQ-1:0]  gnt,
    input wire [N_REQ-1:0]  req_cs      // Requester cs, same order as gnt
);

    // Requester keeps its address until ok
    addr_stable: assert property (@(posedge clk) disable iff (rst)
        rom_cs && !rom_ok |=> $stable(rom_addr))
        else $error("ROM address changed before rom_ok");

    // One owner that still holds its cs until ok
    one_grant: assert property (@(posedge clk) disable iff (rst)
        rom_cs |-> $onehot(gnt & req_cs))
        else $error("ROM grant not held by exactly one requesting owner");

endmodule

bind rom_arbiter snd_sys_asserts arb_checks (
    .clk      (clk),
    .rst      (rst),
    .rom_cs   (rom_cs),
    .rom_ok   (rom_ok),
    .rom_addr (rom_addr),
    .gnt      (gnt),
    .req_cs   ({v1_req.cs, v0_req.cs, host_req.cs})
);

`default_nettype wire

/* dv/snd_sys_tb.sv */
// Sound board playback testbench
// ROM model with 1 to 4 cycle latency, host bus tasks, directed tests
// with sample by sample checks of the mixed output
`timescale 1ns/1ps
`default_nettype none

module snd_sys_tb import snd_pkg::*; ();

    localparam int WAIT_LIMIT = 100;    // Cycles per wait

    logic                    clk, rst, cen, enable_pcm;
    logic [1:0]              fxlevel;
    logic [HOST_AW-1:0]      host_addr;
    logic [DW-1:0]           host_wdata, host_rdata, rom_data;
    logic                    host_wr, host_rd, host_rvalid;
    logic [ROM_AW-1:0]       rom_addr;
    logic                    rom_cs, rom_ok, sample, peak;
    logic signed [SND_W-1:0] snd;

    logic [DW-1:0] rom_mem [0:(1<<ROM_AW)-1];
    int  gain_tab [4] = '{2, 4, 8, 20};    // 4.4 gains, index fxlevel
    int  errors, checks, tests;
    int  fixed_lat;         // 0 for random latency
    int  cen_cnt, rom_wait;
    bit  rom_busy, rd_open, stop_reads;

    snd_sys dut0 (
        .clk         (clk),
        .rst         (rst),
        .cen         (cen),
        .fxlevel     (fxlevel),
        .enable_pcm  (enable_pcm),
        .host_addr   (host_addr),
        .host_wdata  (host_wdata),
        .host_wr     (host_wr),
        .host_rd     (host_rd),
        .host_rdata  (host_rdata),
        .host_rvalid (host_rvalid),
        .rom_addr    (rom_addr),
        .rom_cs      (rom_cs),
        .rom_data    (rom_data),
        .rom_ok      (rom_ok),
        .snd         (snd),
        .sample      (sample),
        .peak        (peak)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Sample tick, one clock in 16
    initial begin
        cen = 1'b0;
        cen_cnt = 0;
        forever begin
            @(posedge clk);
            #1;
            cen = (cen_cnt == 15);
            cen_cnt = (cen_cnt + 1) % 16;
        end
    end

    // ROM model, answers a held cs after 1 to 4 cycles
    initial begin
        rom_ok = 1'b0;
        rom_data = '0;
        rom_busy = 1'b0;
        rom_wait = 0;
        forever begin
            @(posedge clk);
            #1;
            if (rom_ok) begin
                rom_ok = 1'b0;          // ok lasts one cycle
            end else if (rom_busy) begin
                rom_wait = rom_wait - 1;
                if (rom_wait == 0) begin
                    rom_ok = 1'b1;
                    rom_data = rom_mem[rom_addr];
                    rom_busy = 1'b0;
                end
            end else if (rom_cs) begin
                rom_busy = 1'b1;
                rom_wait = (fixed_lat != 0) ? fixed_lat : 1 + int'($urandom % 4);
            end
        end
    end

    // Each host_rvalid answers one earlier host_rd
    always @(negedge clk) begin
        if (host_rvalid) begin
            if (!rd_open) begin
                errors++;
                $display("ERROR t=%0t host_rvalid came without a pending host read", $time);
            end
            rd_open = 1'b0;
        end
        if (host_rd)
            rd_open = 1'b1;
    end

    task automatic check_byte(input string name, input logic [DW-1:0] got,
                              input logic [DW-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH t=%0t %s: got %02h expected %02h", $time, name, got, exp);
        end
    endtask

    task automatic check_snd(input string name, input logic signed [SND_W-1:0] got,
                             input logic signed [SND_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH t=%0t %s: got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH t=%0t %s: got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("ERROR t=%0t timed out waiting for %s", $time, what);
    endtask

    task automatic end_test(input string name, input int e0);
        tests++;
        $display("%-10s %s, %0d errors", name, (errors == e0) ? "ok" : "FAILED", errors - e0);
    endtask

    // Voice select in bit 4, offset in the low nibble
    function automatic logic [HOST_AW-1:0] reg_addr(input int v, input logic [3:0] off);
        return REG_BASE | (HOST_AW'(v) << REG_VOICE_BIT) | HOST_AW'(off);
    endfunction

    // Voice is s * 256 * gain / 16, sum clipped to 16 bits
    function automatic logic signed [SND_W-1:0] mix_model(input logic [DW-1:0] b0,
                                                         input logic [DW-1:0] b1);
        int g;
        int acc;
        g = enable_pcm ? gain_tab[fxlevel] : 0;
        acc = (int'($signed(b0)) + int'($signed(b1))) * 16 * g;
        if (acc > 32767)
            acc = 32767;
        else if (acc < -32768)
            acc = -32768;
        return acc[SND_W-1:0];
    endfunction

    task automatic host_write(input logic [HOST_AW-1:0] addr, input logic [DW-1:0] data);
        host_addr  = addr;
        host_wdata = data;
        host_wr    = 1'b1;
        @(posedge clk);
        #1;
        host_wr = 1'b0;
    endtask

    // lat counts cycles from the host_rd edge to host_rvalid
    task automatic host_read(input logic [HOST_AW-1:0] addr, output logic [DW-1:0] data,
                             output int lat);
        host_addr = addr;
        host_rd   = 1'b1;
        @(posedge clk);
        #1;
        host_rd = 1'b0;
        lat = 1;
        while (!host_rvalid && lat < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            lat++;
        end
        if (!host_rvalid)
            report_timeout("host_rvalid");
        data = host_rdata;
    endtask

    task automatic wait_sample();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (!sample && n < WAIT_LIMIT);
        if (!sample)
            report_timeout("sample");
    endtask

    task automatic program_voice(input int v, input logic [ROM_AW-1:0] s,
                                 input logic [ROM_AW-1:0] e);
        host_write(reg_addr(v, REG_START0), s[7:0]);
        host_write(reg_addr(v, REG_START1), s[15:8]);
        host_write(reg_addr(v, REG_START2), 8'(s[ROM_AW-1:16]));
        host_write(reg_addr(v, REG_END0), e[7:0]);
        host_write(reg_addr(v, REG_END1), e[15:8]);
        host_write(reg_addr(v, REG_END2), 8'(e[ROM_AW-1:16]));
    endtask

    task automatic test_reset();
        int e0;
        int lat;
        logic [DW-1:0] d;
        e0 = errors;
        check_bit("rom_cs", rom_cs, 1'b0);
        check_bit("host_rvalid", host_rvalid, 1'b0);
        check_bit("sample", sample, 1'b0);
        check_bit("peak", peak, 1'b0);
        check_snd("snd", snd, '0);
        host_read(reg_addr(0, REG_STATUS), d, lat);
        check_byte("v0 status", d, 8'h00);
        host_read(reg_addr(1, REG_STATUS), d, lat);
        check_byte("v1 status", d, 8'h00);
        end_test("reset", e0);
    endtask

    task automatic test_rom_reads();
        int e0;
        int lat;
        logic [DW-1:0] d;
        logic [HOST_AW-1:0] a;
        logic [HOST_AW-1:0] open_bus [3] = '{16'hF100, 16'hF7A5, 16'hFFFF};
        e0 = errors;
        for (int i = 0; i < 8; i++) begin
            a = (i == 0) ? 16'h0000 : (i == 1) ? ROM_WIN_END : 16'($urandom % 32'hF000);
            host_read(a, d, lat);
            check_byte($sformatf("rom[%04h]", a), d, rom_mem[a]);
        end
        foreach (open_bus[i]) begin
            host_read(open_bus[i], d, lat);
            check_byte($sformatf("open bus %04h", open_bus[i]), d, UNMAPPED_RD);
            checks++;
            if (lat != 1) begin
                errors++;
                $display("ERROR t=%0t read of %04h answered after %0d cycles, not 1",
                         $time, open_bus[i], lat);
            end
        end
        end_test("rom_reads", e0);
    endtask

    task automatic test_regs();
        int e0;
        int lat;
        logic [DW-1:0] d;
        logic [DW-1:0] vals [6];
        e0 = errors;
        for (int v = 0; v < 2; v++) begin
            for (int k = 0; k < 6; k++) begin
                vals[k] = 8'($urandom);
                if (k == 2 || k == 5)
                    vals[k] = vals[k] & 8'h07;  // 19 bit addresses
                host_write(reg_addr(v, 4'(k)), vals[k]);
            end
            for (int k = 0; k < 6; k++) begin
                host_read(reg_addr(v, 4'(k)), d, lat);
                check_byte($sformatf("v%0d reg %0d", v, k), d, vals[k]);
            end
        end
        host_write(reg_addr(0, REG_CTRL), 8'h01);
        host_read(reg_addr(0, REG_STATUS), d, lat);
        check_byte("v0 status on", d, 8'h01);
        host_write(reg_addr(0, REG_CTRL), 8'h00);
        host_read(reg_addr(0, REG_STATUS), d, lat);
        check_byte("v0 status off", d, 8'h00);
        end_test("regs", e0);
    endtask

    task automatic test_one_shot();
        int e0;
        int lat;
        logic [DW-1:0] d;
        logic [ROM_AW-1:0] start;
        e0 = errors;
        start = 19'h41230;
        fixed_lat = 4;              // Slowest ROM, still inside one tick
        fxlevel = 2'd2;
        program_voice(0, start, start + 19'd5);
        wait_sample();              // Key on right after a tick
        host_write(reg_addr(0, REG_CTRL), 8'h01);
        for (int i = 0; i < 6; i++) begin
            wait_sample();
            check_snd($sformatf("one shot snd %0d", i), snd, mix_model(rom_mem[start + i], 8'h00));
        end
        wait_sample();
        check_snd("snd after end", snd, '0);
        host_read(reg_addr(0, REG_STATUS), d, lat);
        check_byte("v0 status after end", d, 8'h00);
        fixed_lat = 0;
        end_test("one_shot", e0);
    endtask

    task automatic test_saturate();
        int e0;
        e0 = errors;
        for (int a = 'h2000; a < 'h2010; a++)
            rom_mem[a] = 8'h7F;
        fxlevel = 2'd3;
        program_voice(0, 19'h02000, 19'h0200F);
        program_voice(1, 19'h02000, 19'h0200F);
        wait_sample();
        host_write(reg_addr(0, REG_CTRL), 8'h03);
        host_write(reg_addr(1, REG_CTRL), 8'h03);
        wait_sample();
        check_snd("snd clipped", snd, 16'sh7FFF);
        check_bit("peak clipped", peak, 1'b1);
        enable_pcm = 1'b0;          // Gain forced to zero
        wait_sample();
        check_snd("snd muted", snd, '0);
        check_bit("peak muted", peak, 1'b0);
        host_write(reg_addr(0, REG_CTRL), 8'h00);
        host_write(reg_addr(1, REG_CTRL), 8'h00);
        enable_pcm = 1'b1;
        end_test("saturate", e0);
    endtask

    task automatic test_loop();
        int e0;
        int lat;
        logic [DW-1:0] d;
        logic [HOST_AW-1:0] a;
        logic [ROM_AW-1:0] start;
        e0 = errors;
        start = 19'h30100;
        fxlevel = 2'd2;
        program_voice(1, start, start + 19'd3);
        wait_sample();
        host_write(reg_addr(1, REG_CTRL), 8'h03);  // Key-on with loop
        stop_reads = 1'b0;
        fork
            begin
                while (!stop_reads) begin
                    a = 16'($urandom % 32'hF000);
                    host_read(a, d, lat);
                    check_byte($sformatf("rom[%04h]", a), d, rom_mem[a]);
                end
            end
            begin
                // Four bytes, wrapping, no repeats
                for (int i = 0; i < 12; i++) begin
                    wait_sample();
                    check_snd($sformatf("loop snd %0d", i), snd,
                              mix_model(8'h00, rom_mem[start + (i % 4)]));
                end
                stop_reads = 1'b1;
            end
        join
        host_write(reg_addr(1, REG_CTRL), 8'h00);
        end_test("loop", e0);
    endtask

    initial begin
        void'($urandom(48663));
        rst        = 1'b1;
        fxlevel    = 2'd2;
        enable_pcm = 1'b1;
        host_addr  = '0;
        host_wdata = '0;
        host_wr    = 1'b0;
        host_rd    = 1'b0;
        errors     = 0;
        checks     = 0;
        tests      = 0;
        fixed_lat  = 0;
        rd_open    = 1'b0;
        stop_reads = 1'b0;
        for (int i = 0; i < (1 << ROM_AW); i++)
            rom_mem[i] = 8'($urandom);
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset();
        test_rom_reads();
        test_regs();
        test_one_shot();
        test_saturate();
        test_loop();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

/* snd_sys.f */
logic/snd_pkg.sv
logic/snd_bus_if.sv
logic/rom_req_if.sv
logic/snd_host_decode.sv
logic/pcm_voice.sv
logic/rom_arbiter.sv
logic/snd_mixer.sv
logic/snd_sys.sv
dv/snd_sys_asserts.sv
dv/snd_sys_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the sound board testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f snd_sys.f --top-module snd_sys_tb --Mdir obj_dir -o snd_sys_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/snd_sys_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Finished with no errors" "$LOG"; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed, see $LOG"
exit 1
